//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - files:
      - common/fetch_pkg.sv
      - logic/predictor_table.sv
      - fetch/gshare_predictor.sv
      - fetch/branch_target_buffer.sv
      - fetch/fetch_stage.sv
      - logic/fetch_top.sv
  - target: test
    files:
      - verif/fetch_checker.sv
      - verif/fetch_tb.sv

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// basic rv32i word, used for pcs and branch targets
	typedef logic [31:0] rv32i_word;

	localparam rv32i_word RESET_PC = 32'h0000_0000;	// first fetch address

	// decoder side buffering, one credit per packet slot
	localparam int FETCH_CREDITS = 4;
	localparam int CREDIT_W = 3;	// holds 0..FETCH_CREDITS

	// gshare sizing, history width equals counter index width
	localparam int GHR_W = 6;
	localparam int PHT_ENTRIES = 64;
	localparam int PHT_IDX_W = $clog2(PHT_ENTRIES);

	// direct mapped btb, indexed by pc[5:2]
	localparam int BTB_ENTRIES = 16;
	localparam int BTB_IDX_W = 4;
	localparam int BTB_TAG_W = 26;	// pc[31:6]

	// 2-bit saturating counter, msb set means taken
	typedef logic [1:0] counter_t;
	localparam counter_t CNT_INIT = 2'd1;	// weakly not taken
	localparam counter_t CNT_MAX = 2'd3;
	localparam counter_t CNT_MIN = 2'd0;

	typedef logic [GHR_W-1:0] ghr_t;

	typedef struct packed {
		logic valid;
		logic [BTB_TAG_W-1:0] tag;
		rv32i_word target;
	} btb_entry_t;

	localparam btb_entry_t BTB_INIT = '0;	// all entries invalid

	// one packet towards decode
	typedef struct packed {
		logic valid;
		rv32i_word pc;
		logic pred_taken;
		rv32i_word pred_target;	// next pc fetch really went to
		ghr_t ghr;	// history snapshot at lookup
	} fetch_packet_t;

	// resolution of one control flow instruction from execute
	typedef struct packed {
		logic valid;
		rv32i_word pc;
		logic taken;	// actual outcome
		rv32i_word target;	// actual taken target
		logic pred_taken;	// echoed from the packet
		rv32i_word pred_target;
		ghr_t ghr;
	} resolve_t;

	// lookup result from gshare + btb into fetch_stage
	typedef struct packed {
		logic taken;
		logic hit;
		rv32i_word target;
	} predict_t;

endpackage

`default_nettype wire

//--- fetch/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
	input logic clk,
	input logic rst_n,
	input fetch_pkg::rv32i_word fetch_pc,
	output logic hit,
	output fetch_pkg::rv32i_word target,
	input fetch_pkg::resolve_t resolve
);

	import fetch_pkg::*;

	logic [BTB_IDX_W-1:0] rd_idx;
	logic [BTB_IDX_W-1:0] wr_idx;
	logic [BTB_TAG_W-1:0] rd_tag;
	btb_entry_t rd_entry;
	btb_entry_t old_entry;
	btb_entry_t fill_entry;
	logic fill;

	// lookup side, index pc[5:2] and tag pc[31:6]
	assign rd_idx = fetch_pc[BTB_IDX_W+1:2];
	assign rd_tag = fetch_pc[31:BTB_IDX_W+2];

	assign hit = rd_entry.valid && (rd_entry.tag == rd_tag);
	assign target = rd_entry.target;	// only meaningful with hit

	// fill side from execute
	assign wr_idx = resolve.pc[BTB_IDX_W+1:2];

	always_comb
	begin
		fill_entry.valid = 1'b1;
		fill_entry.tag = resolve.pc[31:BTB_IDX_W+2];
		fill_entry.target = resolve.target;	// actual taken target
	end

	// taken branches fill, skip the write when the entry already matches
	assign fill = resolve.valid && resolve.taken && (old_entry != fill_entry);

	predictor_table #(
		.entry_t(btb_entry_t),
		.DEPTH(BTB_ENTRIES),
		.INIT(BTB_INIT)
	) u_btb_store (
		.clk(clk),
		.rst_n(rst_n),
		.rd_idx(rd_idx),
		.rd_data(rd_entry),
		.wr_en(fill),
		.wr_idx(wr_idx),
		.wr_data(fill_entry),
		.wr_old_data(old_entry)
	);

endmodule

`default_nettype wire

//--- fetch/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input logic clk,
	input logic rst_n,
	input fetch_pkg::predict_t pred,
	input fetch_pkg::ghr_t ghr,
	output fetch_pkg::rv32i_word fetch_pc,
	output fetch_pkg::fetch_packet_t pkt,
	input logic credit_return,
	input fetch_pkg::resolve_t resolve
);

	import fetch_pkg::*;

	rv32i_word pc_q;
	logic [CREDIT_W-1:0] credits_q;
	logic active_q;	// low until the first edge after reset release

	rv32i_word seq_pc;	// pc + 4
	rv32i_word pred_next;	// where this fetch goes next
	rv32i_word actual_next;	// where the resolved branch really went
	logic use_target;
	logic mispredict;
	logic fire;	// a packet leaves this cycle

	assign seq_pc = pc_q + 32'd4;

	// predicted target only with a valid btb entry
	assign use_target = pred.taken && pred.hit;
	assign pred_next = use_target ? pred.target : seq_pc;

	// mispredict check, compare real next pc with what fetch followed
	always_comb
	begin
		if (resolve.taken)
			actual_next = resolve.target;
		else
			actual_next = resolve.pc + 32'd4;
		mispredict = resolve.valid && (actual_next != resolve.pred_target);
	end

	// redirect wins over a new packet, zero credits is back-pressure
	assign fire = active_q && (credits_q != '0) && !mispredict;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			active_q <= 1'b0;
		else
			active_q <= 1'b1;
	end

	// pc register with next pc select
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc_q <= RESET_PC;
		else if (mispredict)
			pc_q <= actual_next;	// redirect
		else if (fire)
			pc_q <= pred_next;	// sequential or predicted
	end

	// credit counter, spend and return may coincide
	// decoder never returns more than it got, so no overflow
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			credits_q <= CREDIT_W'(FETCH_CREDITS);
		else
			credits_q <= credits_q - CREDIT_W'(fire) + CREDIT_W'(credit_return);
	end

	// packet assembly, combinational from pc and tables
	always_comb
	begin
		pkt.valid = fire;
		pkt.pc = pc_q;
		pkt.pred_taken = use_target;
		pkt.pred_target = pred_next;
		pkt.ghr = ghr;	// snapshot, echoed back at resolve for training
	end

	assign fetch_pc = pc_q;	// lookup address for both predictors

endmodule

`default_nettype wire

//--- fetch/gshare_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module gshare_predictor (
	input logic clk,
	input logic rst_n,
	input fetch_pkg::rv32i_word fetch_pc,
	output logic taken,
	output fetch_pkg::ghr_t ghr,
	input fetch_pkg::resolve_t resolve
);

	import fetch_pkg::*;

	ghr_t ghr_q;	// history of resolved outcomes, newest in bit 0

	logic [PHT_IDX_W-1:0] rd_idx;
	logic [PHT_IDX_W-1:0] wr_idx;
	counter_t rd_cnt;
	counter_t old_cnt;
	counter_t new_cnt;

	// lookup hashes fetch pc with live history
	assign rd_idx = ghr_q ^ fetch_pc[PHT_IDX_W+1:2];
	// training uses the history echoed back with the branch, the one the lookup saw
	assign wr_idx = resolve.ghr ^ resolve.pc[PHT_IDX_W+1:2];

	// saturating up/down
	always_comb
	begin
		new_cnt = old_cnt;
		if (resolve.taken && (old_cnt != CNT_MAX))
			new_cnt = old_cnt + 2'd1;
		else if (!resolve.taken && (old_cnt != CNT_MIN))
			new_cnt = old_cnt - 2'd1;
	end

	predictor_table #(
		.entry_t(counter_t),
		.DEPTH(PHT_ENTRIES),
		.INIT(CNT_INIT)
	) u_pht (
		.clk(clk),
		.rst_n(rst_n),
		.rd_idx(rd_idx),
		.rd_data(rd_cnt),
		.wr_en(resolve.valid),	// every resolve trains
		.wr_idx(wr_idx),
		.wr_data(new_cnt),
		.wr_old_data(old_cnt)
	);

	// no speculative update, history only moves on resolve
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ghr_q <= '0;
		else if (resolve.valid)
			ghr_q <= {ghr_q[GHR_W-2:0], resolve.taken};
	end

	assign taken = rd_cnt[1];	// counters 2,3 predict taken
	assign ghr = ghr_q;

endmodule

`default_nettype wire

//--- files.f
common/fetch_pkg.sv
logic/predictor_table.sv
fetch/gshare_predictor.sv
fetch/branch_target_buffer.sv
fetch/fetch_stage.sv
logic/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

//--- logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input logic clk,
	input logic rst_n,
	output fetch_pkg::fetch_packet_t pkt,
	input logic credit_return,
	input fetch_pkg::resolve_t resolve
);

	import fetch_pkg::*;

	rv32i_word fetch_pc;
	ghr_t ghr;
	logic gs_taken;	// direction only
	logic btb_hit;
	rv32i_word btb_target;
	predict_t pred;

	// taken needs both a taken counter and a known target
	assign pred.taken = gs_taken & btb_hit;
	assign pred.hit = btb_hit;
	assign pred.target = btb_target;

	fetch_stage u_fetch_stage (
		.clk(clk),
		.rst_n(rst_n),
		.pred(pred),
		.ghr(ghr),
		.fetch_pc(fetch_pc),
		.pkt(pkt),
		.credit_return(credit_return),
		.resolve(resolve)
	);

	gshare_predictor u_gshare (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_pc(fetch_pc),
		.taken(gs_taken),
		.ghr(ghr),
		.resolve(resolve)	// same resolve as fetch_stage sees
	);

	branch_target_buffer u_btb (
		.clk(clk),
		.rst_n(rst_n),
		.fetch_pc(fetch_pc),
		.hit(btb_hit),
		.target(btb_target),
		.resolve(resolve)
	);

endmodule

`default_nettype wire

//--- logic/predictor_table.sv
`timescale 1ns/1ps
`default_nettype none

// generic register table, comb read, clocked write
module predictor_table #(
	parameter type entry_t = logic,
	parameter int DEPTH = 16,
	parameter entry_t INIT = '0
) (
	input logic clk,
	input logic rst_n,
	input logic [$clog2(DEPTH)-1:0] rd_idx,
	output entry_t rd_data,
	input logic wr_en,
	input logic [$clog2(DEPTH)-1:0] wr_idx,
	input entry_t wr_data,
	output entry_t wr_old_data	// current content at wr_idx, for read-modify-write
);

	entry_t mem [DEPTH];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				mem[i] <= INIT;	// every slot back to its init value
			end
		end
		else if (wr_en)
		begin
			mem[wr_idx] <= wr_data;	// visible to reads next cycle
		end
	end

	assign rd_data = mem[rd_idx];	// lookup port
	assign wr_old_data = mem[wr_idx];	// training port

endmodule

`default_nettype wire

//--- verif/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

// bound into fetch_stage, watches the credit counter and redirect priority
module fetch_checker (
	input logic clk,
	input logic rst_n,
	input logic [fetch_pkg::CREDIT_W-1:0] credits,
	input logic pkt_valid,
	input logic mispredict
);

	import fetch_pkg::*;

	// never above the decoder buffer depth
	credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CREDIT_W'(FETCH_CREDITS))
		else $error("credit count above FETCH_CREDITS");

	no_send_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
		pkt_valid |-> (credits != '0))
		else $error("packet sent with zero credits");

	// redirect cycle blocks the packet
	no_send_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
		mispredict |-> !pkt_valid)
		else $error("packet sent in a mispredict cycle");

endmodule

`default_nettype wire

//--- verif/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

	import fetch_pkg::*;

	localparam int TEST_CYCLES = 3000;
	localparam int CYCLE_LIMIT = TEST_CYCLES + 100;	// test length plus margin

	logic clk = 1'b0;
	logic rst_n;
	logic credit_return;
	resolve_t resolve;
	fetch_packet_t pkt;

	integer seed = 32'h4c0b;
	int cycle_cnt = 0;

	// reference model state
	counter_t m_pht [PHT_ENTRIES];
	ghr_t m_ghr;
	btb_entry_t m_btb [BTB_ENTRIES];
	rv32i_word m_pc;
	int m_credits;
	logic m_active;	// fetch starts one cycle after reset release

	// decoder and execute side
	fetch_packet_t in_flight [$];	// packets held by the decoder
	int owed;	// credits still to hand back after a flush
	rv32i_word follow_pc;	// where the next packet has to start
	logic follow_ok;
	logic seen_first;
	int n_pred_taken;
	int n_redirect;
	rv32i_word tgt_set [4] = '{32'h40, 32'h80, 32'h100, 32'h1c0};	// small target pool

	fetch_top u_fetch_top (
		.clk(clk),
		.rst_n(rst_n),
		.pkt(pkt),
		.credit_return(credit_return),
		.resolve(resolve)
	);

	bind fetch_stage fetch_checker u_fetch_checker (
		.clk(clk),
		.rst_n(rst_n),
		.credits(credits_q),
		.pkt_valid(pkt.valid),
		.mispredict(mispredict)
	);

	always #2 clk = ~clk;	// 4 ns period

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
			stop_with_failure();
		end
	end

	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_packet(input fetch_packet_t got, input fetch_packet_t exp);
		if (got !== exp)
		begin
			$display("Mismatch pkt: got %h expected %h at cycle %0d", got, exp, cycle_cnt);
			stop_with_failure();
		end
	endtask

	task automatic check_pc(input rv32i_word got, input rv32i_word exp);
		if (got !== exp)
		begin
			$display("Mismatch pkt.pc: got %h expected %h at cycle %0d", got, exp, cycle_cnt);
			stop_with_failure();
		end
	endtask

	task automatic check_credit(input int got, input int exp);
		if (got != exp)
		begin
			$display("Mismatch credits_q: got %h expected %h at cycle %0d", got, exp, cycle_cnt);
			stop_with_failure();
		end
	endtask

	// real next pc of a resolved branch
	function automatic rv32i_word actual_next(input resolve_t r);
		return r.taken ? r.target : r.pc + 32'd4;
	endfunction

	function automatic logic mispredicted(input resolve_t r);
		return r.valid && (actual_next(r) != r.pred_target);
	endfunction

	// packet the fetch rules give for the model state and this cycle's resolve
	function automatic fetch_packet_t expected_packet();
		fetch_packet_t p;
		logic [GHR_W-1:0] idx;
		btb_entry_t e;
		idx = m_ghr ^ m_pc[7:2];	// gshare hash
		e = m_btb[m_pc[5:2]];
		p.pc = m_pc;
		p.ghr = m_ghr;
		p.pred_taken = m_pht[idx][1] && e.valid && (e.tag == m_pc[31:6]);
		p.pred_target = p.pred_taken ? e.target : m_pc + 32'd4;
		p.valid = m_active && (m_credits != 0) && !mispredicted(resolve);
		return p;
	endfunction

	// sampled mid-cycle, then advance the model to the next edge
	task automatic step_model();
		fetch_packet_t exp;
		fetch_packet_t first;
		logic [GHR_W-1:0] widx;
		exp = expected_packet();
		check_packet(pkt, exp);
		if (pkt.valid)
		begin
			check_credit(int'(u_fetch_top.u_fetch_stage.credits_q), m_credits);
			if (!seen_first)
			begin
				// empty tables, so sequential prediction
				first = '{valid: 1'b1, pc: RESET_PC, pred_taken: 1'b0,
					pred_target: RESET_PC + 32'd4, ghr: '0};
				check_packet(pkt, first);
				seen_first = 1'b1;
			end
			if (follow_ok)
				check_pc(pkt.pc, follow_pc);	// predicted or redirected pc
			follow_pc = exp.pred_target;
			follow_ok = 1'b1;
			in_flight.push_back(exp);
			if (exp.pred_taken)
				n_pred_taken++;
		end
		if (in_flight.size() + owed > FETCH_CREDITS)
		begin
			$display("decoder holds more packets than there are credits");
			stop_with_failure();
		end
		if (mispredicted(resolve))
		begin
			m_pc = actual_next(resolve);
			follow_pc = m_pc;
			follow_ok = 1'b1;
		end
		else if (exp.valid)
			m_pc = exp.pred_target;
		m_credits = m_credits - int'(exp.valid) + int'(credit_return);
		if (resolve.valid)
		begin
			widx = resolve.ghr ^ resolve.pc[7:2];	// history the lookup saw
			if (resolve.taken && (m_pht[widx] != 2'd3))
				m_pht[widx] = m_pht[widx] + 2'd1;
			else if (!resolve.taken && (m_pht[widx] != 2'd0))
				m_pht[widx] = m_pht[widx] - 2'd1;
			m_ghr = {m_ghr[GHR_W-2:0], resolve.taken};
			if (resolve.taken)
			begin
				m_btb[resolve.pc[5:2]].valid = 1'b1;
				m_btb[resolve.pc[5:2]].tag = resolve.pc[31:6];
				m_btb[resolve.pc[5:2]].target = resolve.target;
			end
		end
		m_active = 1'b1;
	endtask

	// decoder returns credits, execute resolves the packet it takes
	task automatic drive_inputs();
		fetch_packet_t head;
		resolve_t r;
		r = '0;
		credit_return <= 1'b0;
		if (owed > 0)
		begin
			credit_return <= 1'b1;	// paying back a flush
			owed--;
		end
		else if ((in_flight.size() > 0) && (($random(seed) & 3) != 0))
		begin
			head = in_flight.pop_front();
			credit_return <= 1'b1;
			if (head.pred_taken || ($random(seed) & 1))
			begin
				r.valid = 1'b1;
				r.pc = head.pc;
				// outcome biased by pc so the counters can learn
				r.taken = head.pc[3] ? (($random(seed) & 3) != 0) : (($random(seed) & 3) == 0);
				r.target = tgt_set[head.pc[5:4]];
				r.pred_taken = head.pred_taken;
				r.pred_target = head.pred_target;
				r.ghr = head.ghr;
				if (mispredicted(r))
				begin
					owed = owed + in_flight.size();	// younger packets are wrong path
					in_flight.delete();
					n_redirect++;
				end
			end
		end
		resolve <= r;
	endtask

	initial
	begin
		rst_n = 1'b0;
		credit_return = 1'b0;
		resolve = '0;
		for (int i = 0; i < PHT_ENTRIES; i++)
			m_pht[i] = 2'd1;	// weakly not taken
		for (int i = 0; i < BTB_ENTRIES; i++)
			m_btb[i] = '0;
		m_ghr = '0;
		m_pc = RESET_PC;
		m_credits = FETCH_CREDITS;
		m_active = 1'b0;
		owed = 0;
		follow_ok = 1'b0;
		seen_first = 1'b0;
		n_pred_taken = 0;
		n_redirect = 0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		for (int c = 0; c < TEST_CYCLES; c++)
		begin
			@(negedge clk);
			step_model();
			@(posedge clk);
			drive_inputs();
		end
		if ((n_pred_taken == 0) || (n_redirect == 0))
		begin
			$display("run ended without a predicted-taken packet or a redirect");
			stop_with_failure();
		end
		else
		begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
